/* src.f */
+incdir+verilog
verilog/owl_dev_pkg.sv
verilog/owl_link_pkg.sv
verilog/uart_serdes.sv
verilog/link_arbiter.sv
verilog/id_reader.sv
verilog/onewire_top.sv
bench/ds2480_model.sv
bench/onewire_tb.sv

/* Makefile */
.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --timescale 1ns/1ps -j 0 \
		--top-module onewire_tb -Mdir obj_dir -f src.f
	./obj_dir/Vonewire_tb

clean:
	rm -rf obj_dir

/* bench/onewire_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "onewire_macros.svh"

module onewire_tb;

    localparam int PASS_CLKS  = 12 * 10 * `OW_CLKS_PER_BIT;   // Twelve bytes per pass
    localparam int LIMIT_CLKS = 40 * PASS_CLKS;

    logic        clk;
    logic        master_reset;
    logic        enable;
    logic        dlsrxd;
    logic        dlstxd;
    logic [31:0] uid;
    logic        uid_update;
    logic        uid_no_device;
    logic [31:0] serial_id;
    logic        serial_update;
    logic        serial_no_device;
    logic        present;
    logic        mem_we;
    logic [9:0]  mem_addr;
    logic [7:0]  mem_wdata;
    logic [15:0] reset_count;
    logic        seq_error;
    logic [31:0] exp_uid;   // Bytes last written to each region
    logic [31:0] exp_ser;
    int          seed;
    int          uid_count = 0;
    int          ser_count = 0;

    onewire_top onewire_top_inst (
        .clk              (clk),
        .master_reset     (master_reset),
        .enable           (enable),
        .dlsrxd           (dlsrxd),
        .dlstxd           (dlstxd),
        .uid              (uid),
        .uid_update       (uid_update),
        .uid_no_device    (uid_no_device),
        .serial_id        (serial_id),
        .serial_update    (serial_update),
        .serial_no_device (serial_no_device)
    );

    ds2480_model ds2480_model_inst (
        .clk         (clk),
        .from_host   (dlstxd),
        .to_host     (dlsrxd),
        .present     (present),
        .mem_we      (mem_we),
        .mem_addr    (mem_addr),
        .mem_wdata   (mem_wdata),
        .reset_count (reset_count),
        .seq_error   (seq_error)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        repeat (LIMIT_CLKS) @(posedge clk);
        $display("Timeout: the tests did not finish within %0d clocks", LIMIT_CLKS);
        $display("ERRORS FOUND");
        $fatal(1, "Watchdog expired");
    end

    task automatic stop_on_error(input string msg);
        $display("** Error at %0t ns: %s", $time, msg);
        $display("ERRORS FOUND");
        $fatal(1, "Stopped at the first error");
    endtask

    task automatic check_reset_outputs();
        assert (dlstxd === 1'b1 && uid_update === 1'b0 && serial_update === 1'b0 &&
                uid_no_device === 1'b0 && serial_no_device === 1'b0 &&
                uid === 32'h0 && serial_id === 32'h0)
            else stop_on_error("outputs not in their reset state");
    endtask

    // Four random bytes at a region, first byte in the low bits of the word
    task automatic load_region(input logic [15:0] base, output logic [31:0] word);
        logic [7:0] b;
        for (int k = 0; k < 4; k++) begin
            b = 8'($random(seed));
            @(posedge clk);
            #10;
            mem_we         = 1'b1;
            mem_addr       = base[9:0] + 10'(k);
            mem_wdata      = b;
            word[8*k +: 8] = b;
        end
        @(posedge clk);
        #10 mem_we = 1'b0;
    endtask

    // Values checked at every update
    always @(negedge clk) begin
        if (!master_reset) begin
            assert (!seq_error) else stop_on_error("the DS2480B model saw a byte out of order");
            if (uid_update) begin
                assert (uid == exp_uid)
                    else stop_on_error($sformatf("uid %08h, expected %08h", uid, exp_uid));
                uid_count++;
            end
            if (serial_update) begin
                assert (serial_id == exp_ser)
                    else stop_on_error($sformatf("serial_id %08h, expected %08h",
                                                 serial_id, exp_ser));
                ser_count++;
            end
        end
    end

    initial begin
        int n_uid;
        int n_ser;
        int n_rst;
        master_reset = 1'b1;
        enable       = 1'b0;
        present      = 1'b1;
        mem_we       = 1'b0;
        mem_addr     = '0;
        mem_wdata    = '0;
        exp_uid      = '0;
        exp_ser      = '0;
        seed         = 32'h39ce_396a;

        repeat (4) begin
            @(posedge clk);
            @(negedge clk);
            check_reset_outputs();
        end
        @(posedge clk);                 // Fifth edge in reset
        #10 master_reset = 1'b0;
        @(negedge clk);
        check_reset_outputs();

        load_region(`OW_UID_ADDR, exp_uid);
        load_region(`OW_SER_ADDR, exp_ser);
        @(posedge clk);
        #10 enable = 1'b1;
        wait (uid_count >= 2 && ser_count >= 2);   // Both readers get turns

        // Rewrite right after a pass ends, so no read is in flight
        wait (uid_update);
        load_region(`OW_UID_ADDR, exp_uid);
        load_region(`OW_SER_ADDR, exp_ser);
        n_uid = uid_count;
        n_ser = ser_count;
        wait (uid_count > n_uid && ser_count > n_ser);
        assert (uid == exp_uid && serial_id == exp_ser)
            else stop_on_error("a reader kept its old value after the memory changed");

        @(posedge clk);
        #10 present = 1'b0;
        wait (uid_no_device && serial_no_device);
        n_uid = uid_count;
        n_ser = ser_count;
        n_rst = int'(reset_count);
        wait (int'(reset_count) >= n_rst + 8);     // Four failed passes
        assert (uid_count == n_uid && ser_count == n_ser)
            else stop_on_error("update pulsed with no device on the bus");

        @(posedge clk);
        #10 present = 1'b1;
        wait (!uid_no_device && !serial_no_device);
        n_uid = uid_count;
        n_ser = ser_count;
        wait (uid_count > n_uid && ser_count > n_ser);

        $display("NO ERRORS");
        $finish;
    end

endmodule

`default_nettype wire

/* bench/ds2480_model.sv */
`timescale 1ns/1ps
`default_nettype none

`include "onewire_macros.svh"

// DS2480B line driver with one 1-wire memory device behind it
module ds2480_model (
    input  wire         clk,
    input  wire         from_host,     // Host transmit line
    output logic        to_host,
    input  wire         present,       // Device answers a reset
    input  wire         mem_we,
    input  wire   [9:0] mem_addr,
    input  wire   [7:0] mem_wdata,
    output logic [15:0] reset_count,   // Reset commands seen
    output logic        seq_error
);

    localparam int CPB = `OW_CLKS_PER_BIT;

    logic [7:0]  mem [0:1023];
    logic        data_mode;
    int          pos;           // Step within a pass, 11 is the reset closing a failed pass
    logic [15:0] addr;

    // Address pattern at start, host writes replace single bytes
    initial begin
        for (int i = 0; i < 1024; i++) mem[i] = 8'(i) ^ 8'(i >> 2);
        forever begin
            @(posedge clk);
            if (mem_we) mem[mem_addr] = mem_wdata;
        end
    end

    task automatic report_sequence_error(input string msg);
        $display("** Error at %0t ns: %s", $time, msg);
        seq_error = 1'b1;
    endtask

    // One 8N1 frame towards the host
    task automatic send_byte(input logic [7:0] b);
        logic [9:0] frame;
        frame = {1'b1, b, 1'b0};
        for (int i = 0; i < 10; i++) begin
            @(posedge clk);
            #10 to_host = frame[i];
            repeat (CPB - 1) @(posedge clk);
        end
    endtask

    task automatic decode_byte(input logic [7:0] b);
        owl_dev_pkg::ds_reply_u reply;
        logic [7:0]             want;
        logic                   answer;
        reply.raw = b;                                   // Data mode echoes
        answer    = data_mode && b != `OW_CMD_CMD_MODE;
        if (!data_mode) begin
            reply.rst.fixed    = 6'b110011;
            reply.rst.presence = present ? 2'b01 : 2'b00;
            answer             = b == `OW_CMD_RESET;
            data_mode          = b == `OW_CMD_DATA_MODE;
        end else if (b == `OW_CMD_CMD_MODE) begin
            data_mode = 1'b0;
        end else if (pos >= 6 && pos <= 9) begin
            reply.raw = mem[addr[9:0] + 10'(pos - 6)];   // Read slot filled by the device
        end

        case (pos)
            0, 11:   want = `OW_CMD_RESET;
            1:       want = `OW_CMD_DATA_MODE;
            2:       want = `OW_SKIP_ROM;
            3:       want = `OW_READ_MEM;
            4, 5:    want = b;   // Address, checked once both bytes are in
            10:      want = `OW_CMD_CMD_MODE;
            default: want = `OW_READ_SLOT;
        endcase
        if (b != want) begin
            report_sequence_error($sformatf("byte %02h at step %0d of a pass, expected %02h",
                                            b, pos, want));
        end
        if (pos == 4) addr[7:0] = b;
        if (pos == 5) begin
            addr[15:8] = b;
            if (addr != `OW_UID_ADDR && addr != `OW_SER_ADDR) begin
                report_sequence_error($sformatf("read address %04h is not a region", addr));
            end
        end
        if (b == `OW_CMD_RESET && (pos == 0 || pos == 11)) reset_count = reset_count + 16'd1;

        if (pos == 0) pos = present ? 1 : 11;   // No data mode after a failed reset
        else if (pos >= 10) pos = 0;
        else pos = pos + 1;

        if (answer) send_byte(reply.raw);
    endtask

    // Receiver samples on the falling clock edge, away from the host's flop outputs
    initial begin
        logic [7:0] b;
        to_host     = 1'b1;
        seq_error   = 1'b0;
        reset_count = '0;
        data_mode   = 1'b0;
        pos         = 0;
        addr        = '0;
        forever begin
            @(negedge clk);
            if (from_host === 1'b0) begin
                repeat (CPB / 2) @(negedge clk);   // Middle of the start bit
                for (int i = 0; i < 8; i++) begin
                    repeat (CPB) @(negedge clk);
                    b[i] = from_host;
                end
                repeat (CPB) @(negedge clk);
                if (from_host !== 1'b1) report_sequence_error("stop bit missing on a host byte");
                else decode_byte(b);
            end
        end
    end

endmodule

`default_nettype wire

/* verilog/onewire_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "onewire_macros.svh"

// Two memory readers sharing one DS2480B serial link
module onewire_top (
    input  wire         clk,
    input  wire         master_reset,
    input  wire         enable,
    input  wire         dlsrxd,     // From the DS2480B
    output logic        dlstxd,     // To the DS2480B
    output logic [31:0] uid,
    output logic        uid_update,
    output logic        uid_no_device,
    output logic [31:0] serial_id,
    output logic        serial_update,
    output logic        serial_no_device
);

    logic                          [1:0] req;
    logic                          [1:0] ack;
    owl_link_pkg::link_req_t       [1:0] req_data;
    owl_link_pkg::link_rsp_t             rsp;
    logic                                tx_start;
    logic                          [7:0] tx_byte;
    logic                                tx_busy;
    logic                                rx_valid;
    logic                          [7:0] rx_byte;

    id_reader #(.MEM_ADDR(`OW_UID_ADDR)) uid_reader (
        .clk          (clk),
        .master_reset (master_reset),
        .enable       (enable),
        .req          (req[0]),
        .req_data     (req_data[0]),
        .ack          (ack[0]),
        .rsp          (rsp),
        .id_value     (uid),
        .update       (uid_update),
        .no_device    (uid_no_device)
    );

    id_reader #(.MEM_ADDR(`OW_SER_ADDR)) ser_reader (
        .clk          (clk),
        .master_reset (master_reset),
        .enable       (enable),
        .req          (req[1]),
        .req_data     (req_data[1]),
        .ack          (ack[1]),
        .rsp          (rsp),
        .id_value     (serial_id),
        .update       (serial_update),
        .no_device    (serial_no_device)
    );

    link_arbiter link_arbiter_inst (
        .clk          (clk),
        .master_reset (master_reset),
        .req          (req),
        .req_data     (req_data),
        .ack          (ack),
        .rsp          (rsp),
        .tx_start     (tx_start),
        .tx_byte      (tx_byte),
        .tx_busy      (tx_busy),
        .rx_valid     (rx_valid),
        .rx_byte      (rx_byte)
    );

    uart_serdes uart_serdes_inst (
        .clk          (clk),
        .master_reset (master_reset),
        .rx_line      (dlsrxd),
        .tx_start     (tx_start),
        .tx_byte      (tx_byte),
        .tx_line      (dlstxd),
        .tx_busy      (tx_busy),
        .rx_valid     (rx_valid),
        .rx_byte      (rx_byte)
    );

endmodule

`default_nettype wire

/* verilog/id_reader.sv */
`timescale 1ns/1ps
`default_nettype none

`include "onewire_macros.svh"

// Reads one 32-bit word from 1-wire memory through the DS2480B, over and over
module id_reader #(
    parameter logic [15:0] MEM_ADDR = 16'h0000
) (
    input  wire                            clk,
    input  wire                            master_reset,
    input  wire                            enable,
    output logic                           req,
    output owl_link_pkg::link_req_t        req_data,
    input  wire                            ack,
    input  wire owl_link_pkg::link_rsp_t   rsp,
    output logic                    [31:0] id_value,
    output logic                           update,
    output logic                           no_device
);

    localparam int GAP = `OW_REREAD_GAP;
    localparam int GW  = $clog2(GAP);

    typedef enum logic [3:0] {
        S_IDLE, S_RESET_CMD, S_RESET_END, S_DATA_MODE, S_SKIP_ROM, S_READ_CMD,
        S_ADDR_LO, S_ADDR_HI, S_READ, S_CMD_MODE, S_GAP
    } rd_state_t;

    rd_state_t     state;
    logic [1:0]    byte_cnt;
    logic [GW-1:0] gap_cnt;
    logic [31:0]   shift;      // First byte read ends up in bits [7:0]
    logic          done;
    logic          xfer;

    assign done = req && ack;   // Handshake phase 2 seen
    assign xfer = state != S_IDLE && state != S_GAP;

    // Byte for the current step; state holds still while req is high
    always_comb begin
        req_data = '{data: `OW_READ_SLOT, want_reply: 1'b1, last: 1'b0};
        case (state)
            S_RESET_CMD: req_data.data = `OW_CMD_RESET;
            S_RESET_END: req_data = '{data: `OW_CMD_RESET, want_reply: 1'b1, last: 1'b1};
            S_DATA_MODE: req_data = '{data: `OW_CMD_DATA_MODE, want_reply: 1'b0, last: 1'b0};
            S_SKIP_ROM:  req_data.data = `OW_SKIP_ROM;
            S_READ_CMD:  req_data.data = `OW_READ_MEM;
            S_ADDR_LO:   req_data.data = MEM_ADDR[7:0];
            S_ADDR_HI:   req_data.data = MEM_ADDR[15:8];
            S_CMD_MODE:  req_data = '{data: `OW_CMD_CMD_MODE, want_reply: 1'b0, last: 1'b1};
            default:     req_data.data = `OW_READ_SLOT;
        endcase
    end

    always_ff @(posedge clk) begin
        if (master_reset) begin
            state     <= S_IDLE;
            req       <= 1'b0;
            byte_cnt  <= '0;
            gap_cnt   <= '0;
            id_value  <= '0;
            update    <= 1'b0;
            no_device <= 1'b0;
        end else begin
            update <= 1'b0;
            if (xfer && !req && !ack) req <= 1'b1;   // Previous ack gone, next byte
            if (done) req <= 1'b0;
            case (state)
                S_IDLE: if (enable) state <= S_RESET_CMD;
                S_RESET_CMD: if (done) begin
                    if (rsp.reply.rst.presence == 2'b01) begin
                        no_device <= 1'b0;
                        state     <= S_DATA_MODE;
                    end else begin
                        no_device <= 1'b1;       // Close the pass with a second reset
                        state     <= S_RESET_END;
                    end
                end
                S_RESET_END: if (done) state <= S_GAP;
                S_DATA_MODE: if (done) state <= S_SKIP_ROM;
                S_SKIP_ROM:  if (done) state <= S_READ_CMD;
                S_READ_CMD:  if (done) state <= S_ADDR_LO;
                S_ADDR_LO:   if (done) state <= S_ADDR_HI;
                S_ADDR_HI:   if (done) state <= S_READ;
                S_READ: if (done) begin
                    byte_cnt <= byte_cnt + 2'd1;
                    if (byte_cnt == 2'd3) state <= S_CMD_MODE;
                end
                S_CMD_MODE: if (done) begin
                    id_value <= shift;
                    update   <= 1'b1;
                    state    <= S_GAP;
                end
                default: begin
                    gap_cnt <= gap_cnt + 1'b1;
                    if (gap_cnt == GW'(GAP - 1)) state <= S_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == S_READ && done) shift <= {rsp.reply.raw, shift[31:8]};
    end

endmodule

`default_nettype wire

/* verilog/link_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

// Shares the serial link between two readers, one locked pass at a time
module link_arbiter (
    input  wire                            clk,
    input  wire                            master_reset,
    input  wire                      [1:0] req,
    input  wire owl_link_pkg::link_req_t [1:0] req_data,
    output logic                     [1:0] ack,
    output owl_link_pkg::link_rsp_t        rsp,
    output logic                           tx_start,
    output logic                     [7:0] tx_byte,
    input  wire                            tx_busy,
    input  wire                            rx_valid,
    input  wire                      [7:0] rx_byte
);

    typedef enum logic [2:0] {ST_IDLE, ST_SEND, ST_TX_WAIT, ST_RX_WAIT, ST_ACK} arb_state_t;

    arb_state_t              state;
    logic                    owner;
    logic                    lock;         // Owner is in the middle of a pass
    logic                    last_served;
    logic                    grant_go;
    logic                    grant_sel;
    owl_link_pkg::link_req_t cur;

    // Locked owner only, otherwise the reader not served last goes first
    always_comb begin
        grant_go  = lock ? req[owner] : |req;
        grant_sel = lock ? owner : (req[~last_served] ? ~last_served : last_served);
    end

    assign ack = (state != ST_ACK) ? 2'b00 : (owner ? 2'b10 : 2'b01);

    assign tx_byte = cur.data;   // Held for the whole transfer

    always_ff @(posedge clk) begin
        if (master_reset) begin
            state       <= ST_IDLE;
            owner       <= 1'b0;
            lock        <= 1'b0;
            last_served <= 1'b1;
            tx_start    <= 1'b0;
        end else begin
            tx_start <= 1'b0;
            case (state)
                ST_IDLE: if (grant_go) begin
                    owner    <= grant_sel;
                    lock     <= 1'b1;
                    tx_start <= 1'b1;
                    state    <= ST_SEND;
                end
                ST_SEND:    state <= ST_TX_WAIT;   // Busy shows up next cycle
                ST_TX_WAIT: if (!tx_busy) state <= cur.want_reply ? ST_RX_WAIT : ST_ACK;
                ST_RX_WAIT: if (rx_valid) state <= ST_ACK;
                default: if (!req[owner]) begin
                    state <= ST_IDLE;
                    if (cur.last) begin
                        lock        <= 1'b0;
                        last_served <= owner;
                    end
                end
            endcase
        end
    end

    // Transfer payload
    always_ff @(posedge clk) begin
        if (state == ST_IDLE && grant_go) cur <= req_data[grant_sel];
        if (state == ST_RX_WAIT && rx_valid) rsp.reply.raw <= rx_byte;
    end

endmodule

`default_nettype wire

/* verilog/uart_serdes.sv */
`timescale 1ns/1ps
`default_nettype none

`include "onewire_macros.svh"

// 8N1 serial transmitter and receiver towards the DS2480B
module uart_serdes (
    input  wire        clk,
    input  wire        master_reset,
    input  wire        rx_line,
    input  wire        tx_start,
    input  wire  [7:0] tx_byte,
    output logic       tx_line,
    output logic       tx_busy,
    output logic       rx_valid,
    output logic [7:0] rx_byte
);

    localparam int CPB = `OW_CLKS_PER_BIT;
    localparam int CW  = $clog2(CPB);
    localparam logic [CW-1:0] BIT_LAST = CW'(CPB - 1);
    localparam logic [CW-1:0] BIT_HALF = CW'(CPB / 2 - 1);   // Middle of a bit

    typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_t;

    logic [9:0]    tx_shift;   // Stop, data and start bit, LSB leaves first
    logic [CW-1:0] tx_cnt;
    logic [3:0]    tx_bits;
    rx_state_t     rx_state;
    logic [2:0]    rx_sync;
    logic [CW-1:0] rx_cnt;
    logic [2:0]    rx_bits;
    logic [7:0]    rx_shift;

    assign tx_line = tx_shift[0];   // Shift register idles at all ones

    always_ff @(posedge clk) begin
        if (master_reset) begin
            tx_shift <= '1;
            tx_cnt   <= '0;
            tx_bits  <= '0;
            tx_busy  <= 1'b0;
        end else if (!tx_busy) begin
            if (tx_start) begin
                tx_shift <= {1'b1, tx_byte, 1'b0};
                tx_cnt   <= '0;
                tx_bits  <= '0;
                tx_busy  <= 1'b1;
            end
        end else if (tx_cnt == BIT_LAST) begin
            tx_cnt   <= '0;
            tx_shift <= {1'b1, tx_shift[9:1]};
            if (tx_bits == 4'd9) begin
                tx_busy <= 1'b0;              // Stop bit done
            end else begin
                tx_bits <= tx_bits + 4'd1;
            end
        end else begin
            tx_cnt <= tx_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (master_reset) begin
            rx_sync  <= 3'b111;
            rx_state <= RX_IDLE;
            rx_cnt   <= '0;
            rx_bits  <= '0;
            rx_valid <= 1'b0;
        end else begin
            rx_sync  <= {rx_sync[1:0], rx_line};
            rx_valid <= 1'b0;
            case (rx_state)
                RX_IDLE: begin
                    rx_cnt <= '0;
                    if (rx_sync[2] && !rx_sync[1]) rx_state <= RX_START;   // Falling edge
                end
                RX_START: begin
                    if (rx_cnt == BIT_HALF) begin
                        rx_cnt   <= '0;
                        rx_bits  <= '0;
                        rx_state <= rx_sync[1] ? RX_IDLE : RX_DATA;   // Glitch, not a start
                    end else begin
                        rx_cnt <= rx_cnt + 1'b1;
                    end
                end
                RX_DATA: begin
                    if (rx_cnt == BIT_LAST) begin
                        rx_cnt  <= '0;
                        rx_bits <= rx_bits + 3'd1;
                        if (rx_bits == 3'd7) rx_state <= RX_STOP;
                    end else begin
                        rx_cnt <= rx_cnt + 1'b1;
                    end
                end
                default: begin
                    if (rx_cnt == BIT_LAST) begin
                        rx_state <= RX_IDLE;
                        rx_valid <= rx_sync[1];   // Framing error drops the byte
                    end else begin
                        rx_cnt <= rx_cnt + 1'b1;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rx_state == RX_DATA && rx_cnt == BIT_LAST) rx_shift <= {rx_sync[1], rx_shift[7:1]};
        if (rx_state == RX_STOP && rx_cnt == BIT_LAST) rx_byte <= rx_shift;
    end

endmodule

`default_nettype wire

/* verilog/owl_link_pkg.sv */
`default_nettype none

// Reader to arbiter byte transfers over the shared serial link
package owl_link_pkg;

    // One byte for the driver, held stable while req is high
    typedef struct packed {
        logic [7:0] data;         // Byte to send
        logic       want_reply;   // Driver answers this byte
        logic       last;         // Release the link once this transfer is acked
    } link_req_t;

    // Reply byte, valid while ack is high
    typedef struct packed {
        owl_dev_pkg::ds_reply_u reply;
    } link_rsp_t;

endpackage

`default_nettype wire

/* verilog/owl_dev_pkg.sv */
`default_nettype none

// Reply formats of the DS2480B line driver
package owl_dev_pkg;

    // Answer to a reset command in command mode
    typedef struct packed {
        logic [5:0] fixed;      // Echo of the command bits and speed setting
        logic [1:0] presence;   // 01 when a device pulled the bus low
    } reset_resp_t;

    // One reply byte, read as a reset response or as plain data
    typedef union packed {
        logic [7:0]  raw;       // Echo or read slot result
        reset_resp_t rst;
    } ds_reply_u;

endpackage

`default_nettype wire

/* verilog/onewire_macros.svh */
`ifndef ONEWIRE_MACROS_SVH
`define ONEWIRE_MACROS_SVH

// Serial timing
`define OW_CLKS_PER_BIT   8         // Clocks per UART bit
`define OW_REREAD_GAP     64        // Idle clocks between two passes of one reader

// DS2480B command-mode codes
`define OW_CMD_RESET      8'hC1     // 1-wire reset, answered with a reset response
`define OW_CMD_DATA_MODE  8'hE1
`define OW_CMD_CMD_MODE   8'hE3

// 1-wire device commands, sent in data mode and echoed by the driver
`define OW_SKIP_ROM       8'hCC
`define OW_READ_MEM       8'hF0
`define OW_READ_SLOT      8'hFF     // All ones lets the device drive the bits

// Memory regions
`define OW_UID_ADDR       16'h0288  // Instrument ID
`define OW_SER_ADDR       16'h00A0  // Serial number

`endif
